// ==== hw/dp_cfg.svh ====
`ifndef DP_CFG_SVH
`define DP_CFG_SVH

// lane configuration for the whole datapath

// bits per signed lane
`define DP_LANE_W 16

// lanes carried by one phit
`define DP_LANES 4

// phits held by each stage register file
`define DP_RF_DEPTH 8

// register file address bits
// must cover DP_RF_DEPTH
`define DP_RF_AW 3

// itr low bits double as an rf address
// so DP_RF_AW stays below DP_LANE_W

`endif

// ==== hw/dp_pkg.sv ====
`include "dp_cfg.svh"

// data side of the datapath
// lanes, phits and lane helpers
package dp_pkg;

    // one signed lane
    // arithmetic wraps at the lane width
    typedef logic signed [`DP_LANE_W-1:0] lane_t;

    // one phit, lane 0 in the low bits
    // elements keep the signed lane type
    typedef lane_t [`DP_LANES-1:0] phit_t;

    // all lanes cleared
    // used where a source is tied low
    localparam phit_t PHIT_ZERO = '0;

    // copy one scalar into every lane
    // itr and imm are shared by all lanes
    function automatic phit_t broadcast(lane_t v);
        phit_t p;
        for (int i = 0; i < `DP_LANES; i++) begin
            p[i] = v;
        end
        return p;
    endfunction

endpackage

// ==== hw/ctrl_pkg.sv ====
`include "dp_cfg.svh"

// control side of the datapath
// opcodes, operand sources and the per-phit instruction
package ctrl_pkg;

    // operand source of a binary stage
    // stage 0 operand a reads zero for SRC_DATA
    // stage 3 reads zero for SRC_ITR
    typedef enum logic [1:0] {
        SRC_DATA = 2'd0,
        SRC_ITR  = 2'd1,
        SRC_IMM  = 2'd2,
        SRC_RF   = 2'd3
    } operand_sel_e;

    // binary lane ops
    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_MIN = 2'd2,
        ALU_MAX = 2'd3
    } alu_op_e;

    // unary lane ops, shr1 is arithmetic
    typedef enum logic [1:0] {
        SCL_PASS = 2'd0,
        SCL_NEG  = 2'd1,
        SCL_SHR1 = 2'd2,
        SCL_ABS  = 2'd3
    } scale_op_e;

    // control of one binary stage
    typedef struct packed {
        operand_sel_e         sel_a;
        operand_sel_e         sel_b;
        alu_op_e              op;
        dp_pkg::lane_t        imm;
        // rf read address taken from itr low bits
        logic                 use_itr;
        logic [`DP_RF_AW-1:0] rd_addr;
        logic [`DP_RF_AW-1:0] wr_addr;
        logic                 wen;
    } alu_stage_t;

    // one instruction, issued with its phit
    typedef struct packed {
        alu_stage_t    alu0;
        alu_stage_t    alu1;
        scale_op_e     scale_op;
        alu_stage_t    alu3;
        dp_pkg::lane_t itr;
    } dp_instr_t;

endpackage

// ==== hw/ctrl_align.sv ====
`timescale 1ns/100ps

// lines up each stage's control with its data
// stage k sees the instruction k cycles late
// write-back copies are one cycle later still
module ctrl_align (
    input  logic                 clk,
    input  logic                 i_rst,
    input  ctrl_pkg::dp_instr_t  i_instr,
    output ctrl_pkg::alu_stage_t o_alu0_ctrl,
    output ctrl_pkg::alu_stage_t o_alu1_ctrl,
    output ctrl_pkg::alu_stage_t o_alu3_ctrl,
    output ctrl_pkg::scale_op_e  o_scale_op,
    output dp_pkg::lane_t        o_itr0,
    output dp_pkg::lane_t        o_itr1,
    output dp_pkg::lane_t        o_itr3,
    output ctrl_pkg::alu_stage_t o_wb0,
    output ctrl_pkg::alu_stage_t o_wb1,
    output ctrl_pkg::alu_stage_t o_wb3
);

    // deepest user is the stage 3 write-back
    localparam int DEPTH = 4;

    // instr_q[k] holds the instruction issued k cycles ago
    ctrl_pkg::dp_instr_t instr_q [1:DEPTH];

    // cleared on reset so no rf write fires
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int k = 1; k <= DEPTH; k++) begin
                instr_q[k] <= '0;
            end
        end else begin
            instr_q[1] <= i_instr;
            for (int k = 2; k <= DEPTH; k++) begin
                instr_q[k] <= instr_q[k-1];
            end
        end
    end

    // stage 0 works on the live instruction
    assign o_alu0_ctrl = i_instr.alu0;
    assign o_itr0      = i_instr.itr;

    // stage 1, one cycle behind
    assign o_alu1_ctrl = instr_q[1].alu1;
    assign o_itr1      = instr_q[1].itr;

    // scaler, two behind
    assign o_scale_op  = instr_q[2].scale_op;

    // stage 3, three behind
    assign o_alu3_ctrl = instr_q[3].alu3;
    assign o_itr3      = instr_q[3].itr;

    // write-back lands with the registered result
    assign o_wb0 = instr_q[1].alu0;
    assign o_wb1 = instr_q[2].alu1;
    assign o_wb3 = instr_q[DEPTH].alu3;

    // an X wen would corrupt a register file
    a_wen_known: assert property (@(posedge clk) disable iff (i_rst)
        !$isunknown({o_wb0.wen, o_wb1.wen, o_wb3.wen}));

endmodule

// ==== hw/operand_select.sv ====
`timescale 1ns/100ps
`include "dp_cfg.svh"

// operand muxes of one binary stage
// also picks the rf read address
module operand_select (
    input  dp_pkg::phit_t        i_prev,
    input  dp_pkg::phit_t        i_rf,
    input  ctrl_pkg::alu_stage_t i_ctrl,
    input  dp_pkg::lane_t        i_itr,
    output dp_pkg::phit_t        o_a,
    output dp_pkg::phit_t        o_b,
    output logic [`DP_RF_AW-1:0] o_rd_addr
);

    // scalars copied across all lanes
    dp_pkg::phit_t itr_bc;
    dp_pkg::phit_t imm_bc;

    // one 4:1 phit mux
    function automatic dp_pkg::phit_t pick(
        ctrl_pkg::operand_sel_e sel,
        dp_pkg::phit_t          prev,
        dp_pkg::phit_t          itr,
        dp_pkg::phit_t          imm,
        dp_pkg::phit_t          rf
    );
        case (sel)
            ctrl_pkg::SRC_DATA: return prev;
            ctrl_pkg::SRC_ITR:  return itr;
            ctrl_pkg::SRC_IMM:  return imm;
            default:            return rf;
        endcase
    endfunction

    assign itr_bc = dp_pkg::broadcast(i_itr);
    assign imm_bc = dp_pkg::broadcast(i_ctrl.imm);

    assign o_a = pick(i_ctrl.sel_a, i_prev, itr_bc, imm_bc, i_rf);
    assign o_b = pick(i_ctrl.sel_b, i_prev, itr_bc, imm_bc, i_rf);

    // loop index in itr addresses the rf
    assign o_rd_addr = i_ctrl.use_itr ? i_itr[`DP_RF_AW-1:0] : i_ctrl.rd_addr;

endmodule

// ==== hw/lane_alu.sv ====
`timescale 1ns/100ps
`include "dp_cfg.svh"

// binary simd alu, one cycle
// same op on every lane
module lane_alu (
    input  logic              clk,
    input  logic              i_rst,
    input  dp_pkg::phit_t     i_a,
    input  dp_pkg::phit_t     i_b,
    input  ctrl_pkg::alu_op_e i_op,
    output dp_pkg::phit_t     o_y
);

    // next result, all lanes
    dp_pkg::phit_t y_d;

    for (genvar g = 0; g < `DP_LANES; g++) begin : g_lane
        // signed views of this lane
        dp_pkg::lane_t a;
        dp_pkg::lane_t b;
        dp_pkg::lane_t r;

        assign a = i_a[g];
        assign b = i_b[g];

        // add and sub wrap at lane width
        // min and max compare signed
        always_comb begin
            case (i_op)
                ctrl_pkg::ALU_ADD: r = a + b;
                ctrl_pkg::ALU_SUB: r = a - b;
                ctrl_pkg::ALU_MIN: r = (a < b) ? a : b;
                ctrl_pkg::ALU_MAX: r = (a > b) ? a : b;
                default:           r = '0;
            endcase
        end

        assign y_d[g] = r;
    end

    // stage output register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_y <= '0;
        end else begin
            o_y <= y_d;
        end
    end

    // op comes through the aligner, must never be X
    a_op_known: assert property (@(posedge clk) disable iff (i_rst) !$isunknown(i_op));

endmodule

// ==== hw/lane_scaler.sv ====
`timescale 1ns/100ps
`include "dp_cfg.svh"

// unary simd scaler, one cycle
module lane_scaler (
    input  logic                clk,
    input  logic                i_rst,
    input  dp_pkg::phit_t       i_x,
    input  ctrl_pkg::scale_op_e i_op,
    output dp_pkg::phit_t       o_y
);

    dp_pkg::phit_t y_d;

    for (genvar g = 0; g < `DP_LANES; g++) begin : g_lane
        dp_pkg::lane_t x;
        dp_pkg::lane_t r;

        assign x = i_x[g];

        // neg and abs of the most negative value wrap to itself
        always_comb begin
            case (i_op)
                ctrl_pkg::SCL_PASS: r = x;
                ctrl_pkg::SCL_NEG:  r = -x;
                // sign kept, rounds toward minus infinity
                ctrl_pkg::SCL_SHR1: r = x >>> 1;
                ctrl_pkg::SCL_ABS:  r = x[`DP_LANE_W-1] ? -x : x;
                default:            r = '0;
            endcase
        end

        assign y_d[g] = r;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_y <= '0;
        end else begin
            o_y <= y_d;
        end
    end

endmodule

// ==== hw/stage_regfile.sv ====
`timescale 1ns/100ps
`include "dp_cfg.svh"

// per-stage phit register file
// sync write, async read
module stage_regfile (
    input  logic                 clk,
    input  logic                 i_wen,
    input  logic [`DP_RF_AW-1:0] i_wr_addr,
    input  logic [`DP_RF_AW-1:0] i_rd_addr,
    input  dp_pkg::phit_t        i_d,
    output dp_pkg::phit_t        o_q
);

    // storage, contents undefined until written
    dp_pkg::phit_t mem [`DP_RF_DEPTH];

    // write-back of the stage result
    always_ff @(posedge clk) begin
        if (i_wen) begin
            mem[i_wr_addr] <= i_d;
        end
    end

    // a write at edge e is visible right after e
    assign o_q = mem[i_rd_addr];

    // a write needs a defined address
    a_wr_addr_known: assert property (@(posedge clk)
        i_wen |-> !$isunknown(i_wr_addr));

endmodule

// ==== hw/data_path.sv ====
`timescale 1ns/100ps
`include "dp_cfg.svh"

// four stage simd streaming datapath
// alu0 -> alu1 -> scaler -> alu3, one phit per cycle
module data_path (
    input  logic                clk,
    input  logic                i_rst,
    input  dp_pkg::phit_t       i_stream,
    input  ctrl_pkg::dp_instr_t i_instr,
    output dp_pkg::phit_t       o_stream
);

    // aligned control
    ctrl_pkg::alu_stage_t alu0_ctrl;
    ctrl_pkg::alu_stage_t alu1_ctrl;
    ctrl_pkg::alu_stage_t alu3_ctrl;
    ctrl_pkg::scale_op_e  scale_op;
    dp_pkg::lane_t        itr0;
    dp_pkg::lane_t        itr1;
    dp_pkg::lane_t        itr3;
    ctrl_pkg::alu_stage_t wb0;
    ctrl_pkg::alu_stage_t wb1;
    ctrl_pkg::alu_stage_t wb3;

    // stage 0
    dp_pkg::phit_t        sel0_a;
    dp_pkg::phit_t        alu0_a;
    dp_pkg::phit_t        alu0_b;
    dp_pkg::phit_t        rf0_q;
    dp_pkg::phit_t        alu0_y;
    logic [`DP_RF_AW-1:0] rd_addr0;

    // stage 1
    dp_pkg::phit_t        alu1_a;
    dp_pkg::phit_t        alu1_b;
    dp_pkg::phit_t        rf1_q;
    dp_pkg::phit_t        alu1_y;
    logic [`DP_RF_AW-1:0] rd_addr1;

    // stage 2
    dp_pkg::phit_t        scl_y;

    // stage 3
    dp_pkg::phit_t        sel3_a;
    dp_pkg::phit_t        sel3_b;
    dp_pkg::phit_t        alu3_a;
    dp_pkg::phit_t        alu3_b;
    dp_pkg::phit_t        rf3_q;
    dp_pkg::phit_t        alu3_y;
    logic [`DP_RF_AW-1:0] rd_addr3;

    ctrl_align u_ctrl_align (
        .clk(clk), .i_rst(i_rst), .i_instr(i_instr),
        .o_alu0_ctrl(alu0_ctrl), .o_alu1_ctrl(alu1_ctrl), .o_alu3_ctrl(alu3_ctrl),
        .o_scale_op(scale_op),
        .o_itr0(itr0), .o_itr1(itr1), .o_itr3(itr3),
        .o_wb0(wb0), .o_wb1(wb1), .o_wb3(wb3)
    );

    // stage 0, stream enters on the data source
    operand_select u_sel0 (
        .i_prev(i_stream), .i_rf(rf0_q), .i_ctrl(alu0_ctrl), .i_itr(itr0),
        .o_a(sel0_a), .o_b(alu0_b), .o_rd_addr(rd_addr0)
    );
    // operand a has no data source here
    assign alu0_a = (alu0_ctrl.sel_a == ctrl_pkg::SRC_DATA) ? dp_pkg::PHIT_ZERO : sel0_a;

    lane_alu u_alu0 (
        .clk(clk), .i_rst(i_rst), .i_a(alu0_a), .i_b(alu0_b), .i_op(alu0_ctrl.op), .o_y(alu0_y)
    );
    stage_regfile u_rf0 (
        .clk(clk), .i_wen(wb0.wen), .i_wr_addr(wb0.wr_addr), .i_rd_addr(rd_addr0),
        .i_d(alu0_y), .o_q(rf0_q)
    );

    // stage 1
    operand_select u_sel1 (
        .i_prev(alu0_y), .i_rf(rf1_q), .i_ctrl(alu1_ctrl), .i_itr(itr1),
        .o_a(alu1_a), .o_b(alu1_b), .o_rd_addr(rd_addr1)
    );
    lane_alu u_alu1 (
        .clk(clk), .i_rst(i_rst), .i_a(alu1_a), .i_b(alu1_b), .i_op(alu1_ctrl.op), .o_y(alu1_y)
    );
    stage_regfile u_rf1 (
        .clk(clk), .i_wen(wb1.wen), .i_wr_addr(wb1.wr_addr), .i_rd_addr(rd_addr1),
        .i_d(alu1_y), .o_q(rf1_q)
    );

    // stage 2, unary only
    lane_scaler u_scl (
        .clk(clk), .i_rst(i_rst), .i_x(alu1_y), .i_op(scale_op), .o_y(scl_y)
    );

    // stage 3
    operand_select u_sel3 (
        .i_prev(scl_y), .i_rf(rf3_q), .i_ctrl(alu3_ctrl), .i_itr(itr3),
        .o_a(sel3_a), .o_b(sel3_b), .o_rd_addr(rd_addr3)
    );
    // itr only addresses the rf here, its operand reads zero
    assign alu3_a = (alu3_ctrl.sel_a == ctrl_pkg::SRC_ITR) ? dp_pkg::PHIT_ZERO : sel3_a;
    assign alu3_b = (alu3_ctrl.sel_b == ctrl_pkg::SRC_ITR) ? dp_pkg::PHIT_ZERO : sel3_b;

    lane_alu u_alu3 (
        .clk(clk), .i_rst(i_rst), .i_a(alu3_a), .i_b(alu3_b), .i_op(alu3_ctrl.op), .o_y(alu3_y)
    );
    stage_regfile u_rf3 (
        .clk(clk), .i_wen(wb3.wen), .i_wr_addr(wb3.wr_addr), .i_rd_addr(rd_addr3),
        .i_d(alu3_y), .o_q(rf3_q)
    );

    // last alu register is the stream output
    assign o_stream = alu3_y;

endmodule

// ==== test/tb_data_path.sv ====
`timescale 1ns/100ps
`include "dp_cfg.svh"

// table driven testbench for the four stage datapath
module tb_data_path;

    localparam int PW        = `DP_LANES * `DP_LANE_W;
    localparam int LATENCY   = 4;
    localparam int MAX_CYCLE = 2000;

    logic                clk;
    logic                i_rst;
    dp_pkg::phit_t       i_stream;
    ctrl_pkg::dp_instr_t i_instr;
    dp_pkg::phit_t       o_stream;

    integer seed;

    // stimulus table and expected outputs
    ctrl_pkg::dp_instr_t instr_tab[$];
    dp_pkg::phit_t       phit_tab[$];
    string               name_tab[$];
    dp_pkg::phit_t       exp_tab[$];

    // mirror register files, index 0..2 for stages 0, 1 and 3
    dp_pkg::phit_t mirror_rf [3][`DP_RF_DEPTH];

    data_path u_data_path (
        .clk(clk),
        .i_rst(i_rst),
        .i_stream(i_stream),
        .i_instr(i_instr),
        .o_stream(o_stream)
    );

    always #20 clk = ~clk;

    // one compare, stops the run at the first mismatch
    task automatic check_value(string name, logic [PW-1:0] exp, logic [PW-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            $display("tests failed");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic ctrl_pkg::alu_stage_t mk_stage(
        ctrl_pkg::operand_sel_e sa,
        ctrl_pkg::operand_sel_e sb,
        ctrl_pkg::alu_op_e      op,
        dp_pkg::lane_t          imm,
        logic                   use_itr,
        logic [`DP_RF_AW-1:0]   rd,
        logic [`DP_RF_AW-1:0]   wr,
        logic                   wen
    );
        ctrl_pkg::alu_stage_t s;
        s.sel_a   = sa;
        s.sel_b   = sb;
        s.op      = op;
        s.imm     = imm;
        s.use_itr = use_itr;
        s.rd_addr = rd;
        s.wr_addr = wr;
        s.wen     = wen;
        return s;
    endfunction

    // zero immediate plus data, no write
    function automatic ctrl_pkg::alu_stage_t pass_stage();
        return mk_stage(ctrl_pkg::SRC_IMM, ctrl_pkg::SRC_DATA, ctrl_pkg::ALU_ADD,
                        '0, 1'b0, '0, '0, 1'b0);
    endfunction

    function automatic ctrl_pkg::dp_instr_t mk_instr(
        ctrl_pkg::alu_stage_t a0,
        ctrl_pkg::alu_stage_t a1,
        ctrl_pkg::scale_op_e  sop,
        ctrl_pkg::alu_stage_t a3,
        dp_pkg::lane_t        itr
    );
        ctrl_pkg::dp_instr_t ins;
        ins.alu0     = a0;
        ins.alu1     = a1;
        ins.scale_op = sop;
        ins.alu3     = a3;
        ins.itr      = itr;
        return ins;
    endfunction

    function automatic dp_pkg::phit_t rand_phit();
        dp_pkg::phit_t p;
        for (int i = 0; i < `DP_LANES; i++) begin
            p[i] = dp_pkg::lane_t'($random(seed));
        end
        return p;
    endfunction

    function automatic ctrl_pkg::operand_sel_e rand_src();
        int r;
        r = $random(seed) & 3;
        // rf reads stay out of random entries, contents unknown
        if (r == 3) begin
            r = 2;
        end
        return ctrl_pkg::operand_sel_e'(r);
    endfunction

    task automatic add_entry(string name, ctrl_pkg::dp_instr_t ins, dp_pkg::phit_t p);
        name_tab.push_back(name);
        instr_tab.push_back(ins);
        phit_tab.push_back(p);
    endtask

    // lane math in int, truncated to the lane width
    function automatic dp_pkg::lane_t ref_alu(ctrl_pkg::alu_op_e op, dp_pkg::lane_t a,
                                              dp_pkg::lane_t b);
        int ia;
        int ib;
        int r;
        ia = int'(a);
        ib = int'(b);
        case (op)
            ctrl_pkg::ALU_ADD: r = ia + ib;
            ctrl_pkg::ALU_SUB: r = ia - ib;
            ctrl_pkg::ALU_MIN: r = (ia < ib) ? ia : ib;
            default:           r = (ia > ib) ? ia : ib;
        endcase
        return dp_pkg::lane_t'(r);
    endfunction

    function automatic dp_pkg::lane_t ref_scale(ctrl_pkg::scale_op_e op, dp_pkg::lane_t x);
        int ix;
        int r;
        ix = int'(x);
        case (op)
            ctrl_pkg::SCL_PASS: r = ix;
            ctrl_pkg::SCL_NEG:  r = -ix;
            ctrl_pkg::SCL_SHR1: r = ix >>> 1;
            default:            r = (ix < 0) ? -ix : ix;
        endcase
        return dp_pkg::lane_t'(r);
    endfunction

    // one operand lane by the source rules of each stage
    function automatic dp_pkg::lane_t ref_operand(ctrl_pkg::operand_sel_e sel, int stage,
                                                  bit is_a, dp_pkg::lane_t prev,
                                                  dp_pkg::lane_t itr, dp_pkg::lane_t imm,
                                                  dp_pkg::lane_t rfv);
        case (sel)
            ctrl_pkg::SRC_DATA: return (stage == 0 && is_a) ? dp_pkg::lane_t'(0) : prev;
            ctrl_pkg::SRC_ITR:  return (stage == 3) ? dp_pkg::lane_t'(0) : itr;
            ctrl_pkg::SRC_IMM:  return imm;
            default:            return rfv;
        endcase
    endfunction

    function automatic dp_pkg::phit_t ref_stage(int stage, ctrl_pkg::alu_stage_t c,
                                                dp_pkg::lane_t itr, dp_pkg::phit_t prev,
                                                dp_pkg::phit_t rfw);
        dp_pkg::phit_t y;
        dp_pkg::lane_t a;
        dp_pkg::lane_t b;
        for (int i = 0; i < `DP_LANES; i++) begin
            a    = ref_operand(c.sel_a, stage, 1'b1, prev[i], itr, c.imm, rfw[i]);
            b    = ref_operand(c.sel_b, stage, 1'b0, prev[i], itr, c.imm, rfw[i]);
            y[i] = ref_alu(c.op, a, b);
        end
        return y;
    endfunction

    function automatic logic [`DP_RF_AW-1:0] rd_addr_of(ctrl_pkg::alu_stage_t c,
                                                       dp_pkg::lane_t itr);
        return c.use_itr ? itr[`DP_RF_AW-1:0] : c.rd_addr;
    endfunction

    // a result written by phit n is seen from phit n+2 on
    task automatic compute_expected();
        ctrl_pkg::dp_instr_t  ins;
        ctrl_pkg::alu_stage_t st [3];
        dp_pkg::phit_t        res [3];
        dp_pkg::phit_t        s2;
        logic                 pend_wen [3];
        logic [`DP_RF_AW-1:0] pend_addr [3];
        dp_pkg::phit_t        pend_data [3];
        for (int k = 0; k < 3; k++) begin
            pend_wen[k] = 1'b0;
        end
        for (int n = 0; n < instr_tab.size(); n++) begin
            ins   = instr_tab[n];
            st[0] = ins.alu0;
            st[1] = ins.alu1;
            st[2] = ins.alu3;
            res[0] = ref_stage(0, st[0], ins.itr, phit_tab[n],
                               mirror_rf[0][rd_addr_of(st[0], ins.itr)]);
            res[1] = ref_stage(1, st[1], ins.itr, res[0],
                               mirror_rf[1][rd_addr_of(st[1], ins.itr)]);
            for (int i = 0; i < `DP_LANES; i++) begin
                s2[i] = ref_scale(ins.scale_op, res[1][i]);
            end
            res[2] = ref_stage(3, st[2], ins.itr, s2,
                               mirror_rf[2][rd_addr_of(st[2], ins.itr)]);
            exp_tab.push_back(res[2]);
            // previous phit's write-back lands now
            for (int k = 0; k < 3; k++) begin
                if (pend_wen[k]) begin
                    mirror_rf[k][pend_addr[k]] = pend_data[k];
                end
                pend_wen[k]  = st[k].wen;
                pend_addr[k] = st[k].wr_addr;
                pend_data[k] = res[k];
            end
        end
    endtask

    task automatic build_table();
        ctrl_pkg::alu_stage_t a0;
        ctrl_pkg::alu_stage_t a1;
        ctrl_pkg::alu_stage_t a3;
        dp_pkg::phit_t        p;
        // pass-through
        for (int i = 0; i < 2; i++) begin
            add_entry("pass", mk_instr(pass_stage(), pass_stage(), ctrl_pkg::SCL_PASS,
                      pass_stage(), '0), rand_phit());
        end
        // every alu and scaler op, imm and itr broadcast
        for (int i = 0; i < 4; i++) begin
            a0 = mk_stage(ctrl_pkg::SRC_IMM, ctrl_pkg::SRC_DATA, ctrl_pkg::alu_op_e'(i),
                          dp_pkg::lane_t'($random(seed)), 1'b0, '0, '0, 1'b0);
            a1 = mk_stage(ctrl_pkg::SRC_DATA, ctrl_pkg::SRC_ITR, ctrl_pkg::alu_op_e'(3 - i),
                          '0, 1'b0, '0, '0, 1'b0);
            a3 = mk_stage(ctrl_pkg::SRC_DATA, (i == 2) ? ctrl_pkg::SRC_ITR : ctrl_pkg::SRC_IMM,
                          ctrl_pkg::alu_op_e'(i), dp_pkg::lane_t'($random(seed)),
                          1'b0, '0, '0, 1'b0);
            add_entry("ops", mk_instr(a0, a1, ctrl_pkg::scale_op_e'(i), a3,
                      dp_pkg::lane_t'($random(seed))), rand_phit());
        end
        // wrap on overflow
        a0 = mk_stage(ctrl_pkg::SRC_IMM, ctrl_pkg::SRC_DATA, ctrl_pkg::ALU_ADD,
                      16'sd1, 1'b0, '0, '0, 1'b0);
        p  = dp_pkg::broadcast(16'sh7fff);
        add_entry("wrap", mk_instr(a0, pass_stage(), ctrl_pkg::SCL_PASS, pass_stage(), '0), p);
        // most negative lane through abs, negatives through shr1
        p = {16'sh8000, 16'shfffd, 16'shff01, 16'sh0005};
        add_entry("abs", mk_instr(pass_stage(), pass_stage(), ctrl_pkg::SCL_ABS,
                  pass_stage(), '0), p);
        add_entry("shr1", mk_instr(pass_stage(), pass_stage(), ctrl_pkg::SCL_SHR1,
                  pass_stage(), '0), p);
        // running sum in the stage 0 rf, fillers keep the write ahead of the read
        a0 = mk_stage(ctrl_pkg::SRC_IMM, ctrl_pkg::SRC_DATA, ctrl_pkg::ALU_ADD,
                      '0, 1'b0, '0, 3'd2, 1'b1);
        add_entry("acc_init", mk_instr(a0, pass_stage(), ctrl_pkg::SCL_PASS,
                  pass_stage(), '0), rand_phit());
        for (int i = 0; i < 3; i++) begin
            add_entry("acc_fill", mk_instr(pass_stage(), pass_stage(), ctrl_pkg::SCL_PASS,
                      pass_stage(), '0), rand_phit());
            a0 = mk_stage(ctrl_pkg::SRC_RF, ctrl_pkg::SRC_DATA, ctrl_pkg::ALU_ADD,
                          '0, 1'b0, 3'd2, 3'd2, 1'b1);
            add_entry("acc_sum", mk_instr(a0, pass_stage(), ctrl_pkg::SCL_PASS,
                      pass_stage(), '0), rand_phit());
        end
        // itr addressed read, stage 3 rf written on the same phit
        a0 = mk_stage(ctrl_pkg::SRC_IMM, ctrl_pkg::SRC_DATA, ctrl_pkg::ALU_ADD,
                      '0, 1'b0, '0, 3'd5, 1'b1);
        a3 = mk_stage(ctrl_pkg::SRC_IMM, ctrl_pkg::SRC_DATA, ctrl_pkg::ALU_SUB,
                      16'sd7, 1'b0, '0, 3'd1, 1'b1);
        add_entry("itr_wr", mk_instr(a0, pass_stage(), ctrl_pkg::SCL_NEG, a3, '0), rand_phit());
        add_entry("itr_fill", mk_instr(pass_stage(), pass_stage(), ctrl_pkg::SCL_PASS,
                  pass_stage(), '0), rand_phit());
        // low bits of 0x0a3d address word 5, stage 0 operand a reads zero
        a0 = mk_stage(ctrl_pkg::SRC_DATA, ctrl_pkg::SRC_RF, ctrl_pkg::ALU_SUB,
                      '0, 1'b1, 3'd0, '0, 1'b0);
        a1 = mk_stage(ctrl_pkg::SRC_DATA, ctrl_pkg::SRC_ITR, ctrl_pkg::ALU_ADD,
                      '0, 1'b0, '0, '0, 1'b0);
        a3 = mk_stage(ctrl_pkg::SRC_RF, ctrl_pkg::SRC_DATA, ctrl_pkg::ALU_MAX,
                      '0, 1'b0, 3'd1, '0, 1'b0);
        add_entry("itr_rd", mk_instr(a0, a1, ctrl_pkg::SCL_PASS, a3, 16'sh0a3d), rand_phit());
        // back to back random instructions, four in flight
        for (int i = 0; i < 8; i++) begin
            a0 = mk_stage(rand_src(), rand_src(), ctrl_pkg::alu_op_e'($random(seed) & 3),
                          dp_pkg::lane_t'($random(seed)), 1'b0, '0, '0, 1'b0);
            a1 = mk_stage(rand_src(), rand_src(), ctrl_pkg::alu_op_e'($random(seed) & 3),
                          dp_pkg::lane_t'($random(seed)), 1'b0, '0, '0, 1'b0);
            a3 = mk_stage(rand_src(), rand_src(), ctrl_pkg::alu_op_e'($random(seed) & 3),
                          dp_pkg::lane_t'($random(seed)), 1'b0, '0, '0, 1'b0);
            add_entry("b2b", mk_instr(a0, a1, ctrl_pkg::scale_op_e'($random(seed) & 3), a3,
                      dp_pkg::lane_t'($random(seed))), rand_phit());
        end
    endtask

    // bounds the whole run
    initial begin
        for (int c = 0; c < MAX_CYCLE; c++) begin
            @(posedge clk);
        end
        $display("timeout, the run did not finish in %0d cycles", MAX_CYCLE);
        $display("tests failed");
        $fatal(1, "timeout");
    end

    initial begin
        int n;
        clk      = 1'b0;
        i_rst    = 1'b1;
        seed     = 32'h2498;
        // live data during reset, the stage registers must still read zero
        i_stream = rand_phit();
        i_instr  = '0;

        build_table();
        compute_expected();
        n = instr_tab.size();

        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
        end
        #2;
        i_rst    = 1'b0;
        i_stream = '0;
        #1;
        check_value("reset", '0, o_stream);

        // sample 1 ns after the edge, drive 2 ns after it
        for (int c = 0; c < n + LATENCY; c++) begin
            @(posedge clk);
            #1;
            if (c >= LATENCY) begin
                check_value(name_tab[c-LATENCY], exp_tab[c-LATENCY], o_stream);
            end else begin
                check_value("pipe_fill", '0, o_stream);
            end
            #1;
            if (c < n) begin
                i_instr  = instr_tab[c];
                i_stream = phit_tab[c];
            end else begin
                i_instr  = '0;
                i_stream = '0;
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hw
hw/dp_pkg.sv
hw/ctrl_pkg.sv
hw/ctrl_align.sv
hw/operand_select.sv
hw/lane_alu.sv
hw/lane_scaler.sv
hw/stage_regfile.sv
hw/data_path.sv
test/tb_data_path.sv

// ==== run.sh ====
#!/bin/sh
# build and run the datapath testbench with Verilator
# the exit status of the simulation is the verdict
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f flist.f \
    --top-module tb_data_path \
    -o tb_data_path

./obj_dir/tb_data_path
